// File: include/wb_mem_defs.svh
`ifndef WB_MEM_DEFS_SVH
`define WB_MEM_DEFS_SVH

// Bus widths, byte addressed
`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32

// Port and arbiter wiring is written for exactly four masters
`define WB_N_MASTERS 4

// Memory depth in data words
`define WB_MEM_WORDS 256

// Byte address window of the memory target
`define WB_MEM_BASE 32'h0000_1000
`define WB_MEM_LIMIT (`WB_MEM_BASE + 32'd1023)

`endif

// File: rtl/wb_bus_pkg.sv
`include "wb_mem_defs.svh"

package wb_bus_pkg;

	// Byte address
	typedef logic [`WB_ADDR_WIDTH-1:0] wb_adr_t;

	// Data word, read or write
	typedef logic [`WB_DATA_WIDTH-1:0] wb_dat_t;

	// One select bit per byte lane
	typedef logic [`WB_DATA_WIDTH/8-1:0] wb_sel_t;

endpackage

// File: rtl/wb_ic_pkg.sv
`include "wb_mem_defs.svh"

package wb_ic_pkg;

	// Index of a bus master
	typedef logic [$clog2(`WB_N_MASTERS)-1:0] wb_mid_t;

	// Target latched by a master port, TGT_NONE while idle
	typedef enum logic [1:0] {
		TGT_MEM  = 2'd0,
		TGT_DERR = 2'd1,
		TGT_NONE = 2'd2
	} wb_tgt_e;

endpackage

// File: rtl/wb_rr_arbiter.sv
`timescale 1ns/10ps
`include "wb_mem_defs.svh"

module wb_rr_arbiter (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic [`WB_N_MASTERS-1:0]  req_i,
	output logic                      gnt_o,
	output wb_ic_pkg::wb_mid_t        gnt_id_o
);

	import wb_ic_pkg::*;

	logic                     last_vld;
	wb_mid_t                  last_id;
	logic [`WB_N_MASTERS-1:0] above;
	logic [`WB_N_MASTERS-1:0] masked_req;
	logic [`WB_N_MASTERS-1:0] cand;
	wb_mid_t                  pick_id;

	// Requesters strictly above the last grant get first pick
	always_comb begin
		for (int i = 0; i < `WB_N_MASTERS; i++) begin
			above[i] = last_vld && (i > int'(last_id));
		end
	end

	assign masked_req = req_i & above;
	// Nothing above the last grant, so wrap to the lowest index
	assign cand = (|masked_req) ? masked_req : req_i;

	always_comb begin
		pick_id = '0;
		for (int i = `WB_N_MASTERS-1; i >= 0; i--) begin
			if (cand[i]) begin
				pick_id = wb_mid_t'(i);
			end
		end
	end

	// gnt_o doubles as the state: low is idle, high is granted
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			gnt_id_o <= '0;
			last_vld <= 1'b0;
			last_id  <= '0;
		end else if (!gnt_o) begin
			if (|req_i) begin
				gnt_o    <= 1'b1;
				gnt_id_o <= pick_id;
				last_vld <= 1'b1;
				last_id  <= pick_id;
			end
		end else if (!req_i[gnt_id_o]) begin
			// Owner has finished its cycle
			gnt_o <= 1'b0;
		end
	end

endmodule

// File: rtl/wb_master_port.sv
`timescale 1ns/10ps
`include "wb_mem_defs.svh"

module wb_master_port (
	input  logic                clk,
	input  logic                rstn,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  wb_bus_pkg::wb_adr_t adr_i,
	input  logic                done_i,
	output wb_ic_pkg::wb_tgt_e  tgt_o
);

	import wb_ic_pkg::*;

	logic in_window;

	assign in_window = (adr_i >= `WB_MEM_BASE) && (adr_i <= `WB_MEM_LIMIT);

	// The latched target is the whole state, TGT_NONE means idle
	always_ff @(posedge clk) begin
		if (!rstn) begin
			tgt_o <= TGT_NONE;
		end else begin
			case (tgt_o)
				TGT_NONE: begin
					if (cyc_i && stb_i) begin
						tgt_o <= in_window ? TGT_MEM : TGT_DERR;
					end
				end
				default: begin
					// Ack or err already routed back to this master
					if (done_i) begin
						tgt_o <= TGT_NONE;
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/wb_decode_err_slave.sv
`timescale 1ns/10ps

module wb_decode_err_slave (
	input  logic clk,
	input  logic rstn,
	input  logic cyc_i,
	input  logic stb_i,
	output logic err_o
);

	logic new_req;

	// A strobe still high during the err pulse is the same access
	assign new_req = cyc_i && stb_i && !err_o;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_o <= 1'b0;
		end else begin
			err_o <= new_req;
		end
	end

endmodule

// File: rtl/wb_interconnect_4x1.sv
`timescale 1ns/10ps
`include "wb_mem_defs.svh"

module wb_interconnect_4x1 (
	input  logic                                     clk,
	input  logic                                     rstn,
	input  logic [`WB_N_MASTERS-1:0]                 m_cyc_i,
	input  logic [`WB_N_MASTERS-1:0]                 m_stb_i,
	input  logic [`WB_N_MASTERS-1:0]                 m_we_i,
	input  wb_bus_pkg::wb_adr_t [`WB_N_MASTERS-1:0]  m_adr_i,
	input  wb_bus_pkg::wb_dat_t [`WB_N_MASTERS-1:0]  m_dat_i,
	input  wb_bus_pkg::wb_sel_t [`WB_N_MASTERS-1:0]  m_sel_i,
	output wb_bus_pkg::wb_dat_t [`WB_N_MASTERS-1:0]  m_dat_o,
	output logic [`WB_N_MASTERS-1:0]                 m_ack_o,
	output logic [`WB_N_MASTERS-1:0]                 m_err_o,
	output logic                                     s_cyc_o,
	output logic                                     s_stb_o,
	output logic                                     s_we_o,
	output wb_bus_pkg::wb_adr_t                      s_adr_o,
	output wb_bus_pkg::wb_dat_t                      s_dat_o,
	output wb_bus_pkg::wb_sel_t                      s_sel_o,
	input  wb_bus_pkg::wb_dat_t                      s_dat_i,
	input  logic                                     s_ack_i,
	input  logic                                     s_err_i
);

	import wb_ic_pkg::*;

	wb_tgt_e                  tgt [`WB_N_MASTERS];
	logic [`WB_N_MASTERS-1:0] mem_req;
	logic [`WB_N_MASTERS-1:0] derr_req;
	logic [`WB_N_MASTERS-1:0] mem_own;
	logic [`WB_N_MASTERS-1:0] derr_own;
	logic [`WB_N_MASTERS-1:0] m_done;
	logic                     mem_gnt;
	logic                     derr_gnt;
	wb_mid_t                  mem_gnt_id;
	wb_mid_t                  derr_gnt_id;
	logic                     derr_cyc;
	logic                     derr_stb;
	logic                     derr_err;

	for (genvar m = 0; m < `WB_N_MASTERS; m++) begin : g_port
		wb_master_port u_port (
			.clk    (clk),
			.rstn   (rstn),
			.cyc_i  (m_cyc_i[m]),
			.stb_i  (m_stb_i[m]),
			.adr_i  (m_adr_i[m]),
			.done_i (m_done[m]),
			.tgt_o  (tgt[m])
		);

		// One request bit per target
		assign mem_req[m]  = (tgt[m] == TGT_MEM);
		assign derr_req[m] = (tgt[m] == TGT_DERR);

		assign mem_own[m]  = mem_gnt && (mem_gnt_id == wb_mid_t'(m));
		assign derr_own[m] = derr_gnt && (derr_gnt_id == wb_mid_t'(m));

		// Responses reach only the grant holder, decode-fail data is zero
		assign m_ack_o[m] = mem_own[m] & s_ack_i;
		assign m_err_o[m] = (mem_own[m] & s_err_i) | (derr_own[m] & derr_err);
		assign m_dat_o[m] = mem_own[m] ? s_dat_i : '0;
		assign m_done[m]  = m_ack_o[m] | m_err_o[m];
	end

	wb_rr_arbiter u_mem_arb (
		.clk      (clk),
		.rstn     (rstn),
		.req_i    (mem_req),
		.gnt_o    (mem_gnt),
		.gnt_id_o (mem_gnt_id)
	);

	wb_rr_arbiter u_derr_arb (
		.clk      (clk),
		.rstn     (rstn),
		.req_i    (derr_req),
		.gnt_o    (derr_gnt),
		.gnt_id_o (derr_gnt_id)
	);

	// Memory request mux, all zero while ungranted
	assign s_cyc_o = mem_gnt & m_cyc_i[mem_gnt_id];
	assign s_stb_o = mem_gnt & m_stb_i[mem_gnt_id];
	assign s_we_o  = mem_gnt & m_we_i[mem_gnt_id];
	assign s_adr_o = mem_gnt ? m_adr_i[mem_gnt_id] : '0;
	assign s_dat_o = mem_gnt ? m_dat_i[mem_gnt_id] : '0;
	assign s_sel_o = mem_gnt ? m_sel_i[mem_gnt_id] : '0;

	// The decode-fail target only looks at the strobes
	assign derr_cyc = derr_gnt & m_cyc_i[derr_gnt_id];
	assign derr_stb = derr_gnt & m_stb_i[derr_gnt_id];

	wb_decode_err_slave u_derr (
		.clk   (clk),
		.rstn  (rstn),
		.cyc_i (derr_cyc),
		.stb_i (derr_stb),
		.err_o (derr_err)
	);

endmodule

// File: rtl/wb_sram_slave.sv
`timescale 1ns/10ps
`include "wb_mem_defs.svh"

module wb_sram_slave (
	input  logic                clk,
	input  logic                rstn,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  logic                we_i,
	input  wb_bus_pkg::wb_adr_t adr_i,
	input  wb_bus_pkg::wb_dat_t dat_i,
	input  wb_bus_pkg::wb_sel_t sel_i,
	output wb_bus_pkg::wb_dat_t dat_o,
	output logic                ack_o
);

	import wb_bus_pkg::*;

	localparam int IDX_W = $clog2(`WB_MEM_WORDS);

	wb_dat_t          mem [`WB_MEM_WORDS];
	wb_adr_t          offset;
	logic [IDX_W-1:0] word_idx;
	logic             access;

	// Word index within the window, byte offset bits dropped
	assign offset   = adr_i - `WB_MEM_BASE;
	assign word_idx = offset[IDX_W+1:2];

	// Strobe during the ack cycle belongs to the access just answered
	assign access = cyc_i && stb_i && !ack_o;

	always_ff @(posedge clk) begin
		if (access && we_i) begin
			for (int b = 0; b < `WB_DATA_WIDTH/8; b++) begin
				if (sel_i[b]) begin
					mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			dat_o <= mem[word_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

endmodule

// File: rtl/wb_mem_subsys.sv
`timescale 1ns/10ps
`include "wb_mem_defs.svh"

module wb_mem_subsys (
	input  logic                                     clk,
	input  logic                                     rstn,
	input  logic [`WB_N_MASTERS-1:0]                 m_cyc_i,
	input  logic [`WB_N_MASTERS-1:0]                 m_stb_i,
	input  logic [`WB_N_MASTERS-1:0]                 m_we_i,
	input  wb_bus_pkg::wb_adr_t [`WB_N_MASTERS-1:0]  m_adr_i,
	input  wb_bus_pkg::wb_dat_t [`WB_N_MASTERS-1:0]  m_dat_i,
	input  wb_bus_pkg::wb_sel_t [`WB_N_MASTERS-1:0]  m_sel_i,
	output wb_bus_pkg::wb_dat_t [`WB_N_MASTERS-1:0]  m_dat_o,
	output logic [`WB_N_MASTERS-1:0]                 m_ack_o,
	output logic [`WB_N_MASTERS-1:0]                 m_err_o
);

	import wb_bus_pkg::*;

	// Memory side of the interconnect
	logic    s_cyc;
	logic    s_stb;
	logic    s_we;
	wb_adr_t s_adr;
	wb_dat_t s_dat_w;
	wb_sel_t s_sel;
	wb_dat_t s_dat_r;
	logic    s_ack;

	wb_interconnect_4x1 u_ic (
		.clk     (clk),
		.rstn    (rstn),
		.m_cyc_i (m_cyc_i),
		.m_stb_i (m_stb_i),
		.m_we_i  (m_we_i),
		.m_adr_i (m_adr_i),
		.m_dat_i (m_dat_i),
		.m_sel_i (m_sel_i),
		.m_dat_o (m_dat_o),
		.m_ack_o (m_ack_o),
		.m_err_o (m_err_o),
		.s_cyc_o (s_cyc),
		.s_stb_o (s_stb),
		.s_we_o  (s_we),
		.s_adr_o (s_adr),
		.s_dat_o (s_dat_w),
		.s_sel_o (s_sel),
		.s_dat_i (s_dat_r),
		.s_ack_i (s_ack),
		// The memory never signals an error
		.s_err_i (1'b0)
	);

	wb_sram_slave u_sram (
		.clk   (clk),
		.rstn  (rstn),
		.cyc_i (s_cyc),
		.stb_i (s_stb),
		.we_i  (s_we),
		.adr_i (s_adr),
		.dat_i (s_dat_w),
		.sel_i (s_sel),
		.dat_o (s_dat_r),
		.ack_o (s_ack)
	);

endmodule

// File: bench/wb_clk_gen.sv
`timescale 1ns/10ps

module wb_clk_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic rstn_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

	// Reset held over RESET_CYCLES rising edges, released on a falling edge
	initial begin
		rstn_o = 1'b0;
		repeat (RESET_CYCLES) begin
			@(posedge clk_o);
		end
		@(negedge clk_o);
		rstn_o = 1'b1;
	end

endmodule

// File: bench/wb_mem_subsys_tb.sv
`timescale 1ns/10ps
`include "wb_mem_defs.svh"

module wb_mem_subsys_tb;

	import wb_bus_pkg::*;

	localparam int RST_CYCLES = 5;
	localparam int N_BYTE_OPS = 8;
	localparam int N_WARM     = 8;
	localparam int N_RAND     = 16;
	// Write/read, byte lanes, decode fail, concurrent, round-robin
	localparam int N_TXN = 2 + (1 + 2 * N_BYTE_OPS) + 4 + 4 * (N_WARM + N_RAND) + 7;

	typedef struct packed {
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
		wb_dat_t rdat;
		logic    ack;
		logic    err;
		logic    extra;
	} txn_t;

	logic                           clk;
	logic                           rstn;
	logic [`WB_N_MASTERS-1:0]       m_cyc;
	logic [`WB_N_MASTERS-1:0]       m_stb;
	logic [`WB_N_MASTERS-1:0]       m_we;
	wb_adr_t [`WB_N_MASTERS-1:0]    m_adr;
	wb_dat_t [`WB_N_MASTERS-1:0]    m_dat;
	wb_sel_t [`WB_N_MASTERS-1:0]    m_sel;
	wb_dat_t [`WB_N_MASTERS-1:0]    m_dat_o;
	logic [`WB_N_MASTERS-1:0]       m_ack_o;
	logic [`WB_N_MASTERS-1:0]       m_err_o;

	wb_dat_t shadow [`WB_MEM_WORDS];
	txn_t    txn_q [$];
	string   name_q [$];
	int      done_order [$];
	int      val_errs;
	int      other_errs;
	integer  seed;

	wb_clk_gen #(
		.PERIOD_NS    (10),
		.RESET_CYCLES (RST_CYCLES)
	) u_clk_gen (
		.clk_o  (clk),
		.rstn_o (rstn)
	);

	wb_mem_subsys dut (
		.clk     (clk),
		.rstn    (rstn),
		.m_cyc_i (m_cyc),
		.m_stb_i (m_stb),
		.m_we_i  (m_we),
		.m_adr_i (m_adr),
		.m_dat_i (m_dat),
		.m_sel_i (m_sel),
		.m_dat_o (m_dat_o),
		.m_ack_o (m_ack_o),
		.m_err_o (m_err_o)
	);

	// Shadow memory model that returns the expected read data and flags a decode fail
	function automatic wb_dat_t model_access(input logic we, input wb_adr_t adr,
			input wb_dat_t dat, input wb_sel_t sel, output logic exp_err);
		int      idx;
		wb_dat_t old;
		exp_err = (adr < `WB_MEM_BASE) || (adr > `WB_MEM_LIMIT);
		if (exp_err) begin
			return '0;
		end
		idx = int'((adr - `WB_MEM_BASE) >> 2);
		old = shadow[idx];
		if (we) begin
			for (int b = 0; b < `WB_DATA_WIDTH / 8; b++) begin
				if (sel[b]) begin
					shadow[idx][8*b +: 8] = dat[8*b +: 8];
				end
			end
		end
		return old;
	endfunction

	// One classic cycle on master m with the response queued for checking
	task automatic bus_access(input int m, input string name, input logic we,
			input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		txn_t t;
		t = '0;
		t.we = we;
		t.adr = adr;
		t.dat = dat;
		t.sel = sel;
		@(negedge clk);
		m_cyc[m] = 1'b1;
		m_stb[m] = 1'b1;
		m_we[m] = we;
		m_adr[m] = adr;
		m_dat[m] = dat;
		m_sel[m] = sel;
		do begin
			@(negedge clk);
		end while (!(m_ack_o[m] || m_err_o[m]));
		t.rdat = m_dat_o[m];
		t.ack = m_ack_o[m];
		t.err = m_err_o[m];
		done_order.push_back(m);
		m_cyc[m] = 1'b0;
		m_stb[m] = 1'b0;
		m_we[m] = 1'b0;
		@(negedge clk);
		// A second pulse here would mean a doubled response
		t.extra = m_ack_o[m] | m_err_o[m];
		txn_q.push_back(t);
		name_q.push_back(name);
	endtask

	// Random traffic inside the quarter of memory owned by master m
	task automatic master_traffic(input int m);
		wb_adr_t base;
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
		logic    we;
		base = `WB_MEM_BASE + m * (`WB_MEM_WORDS / `WB_N_MASTERS) * 4;
		for (int k = 0; k < N_WARM; k++) begin
			dat = $random(seed);
			bus_access(m, "concurrent", 1'b1, base + 4 * k, dat, 4'hf);
		end
		for (int k = 0; k < N_RAND; k++) begin
			adr = base + 4 * ($unsigned($random(seed)) % N_WARM);
			we = $random(seed);
			dat = $random(seed);
			sel = we ? wb_sel_t'($random(seed)) : 4'hf;
			bus_access(m, "concurrent", we, adr, dat, sel);
		end
	endtask

	// Comparison against the shadow model
	initial begin
		txn_t    t;
		string   name;
		wb_dat_t exp_dat;
		logic    exp_err;
		forever begin
			@(posedge clk);
			while (txn_q.size() > 0) begin
				t = txn_q.pop_front();
				name = name_q.pop_front();
				exp_dat = model_access(t.we, t.adr, t.dat, t.sel, exp_err);
				assert (t.err === exp_err) else begin
					val_errs++;
					$display("error %s: err expected %b actual %b", name, exp_err, t.err);
				end
				assert (t.ack === !exp_err) else begin
					val_errs++;
					$display("error %s: ack expected %b actual %b", name, !exp_err, t.ack);
				end
				if (!t.we || exp_err) begin
					assert (t.rdat === exp_dat) else begin
						val_errs++;
						$display("error %s: data at %h expected %h actual %h",
							name, t.adr, exp_dat, t.rdat);
					end
				end
				assert (!t.extra) else begin
					other_errs++;
					$display("%s: response at %h stayed high a second cycle", name, t.adr);
				end
			end
		end
	end

	initial begin
		repeat (RST_CYCLES + 200 * N_TXN) begin
			@(posedge clk);
		end
		$display("watchdog: run did not finish within %0d cycles", RST_CYCLES + 200 * N_TXN);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
		seed = 46082;
		val_errs = 0;
		other_errs = 0;
		m_cyc = '0;
		m_stb = '0;
		m_we = '0;
		m_adr = '0;
		m_dat = '0;
		m_sel = '0;
		wait (rstn === 1'b1);
		repeat (3) begin
			@(negedge clk);
			assert (m_ack_o === '0 && m_err_o === '0) else begin
				val_errs++;
				$display("error reset: expected ack 0000 err 0000 actual ack %b err %b",
					m_ack_o, m_err_o);
			end
		end
		adr = `WB_MEM_BASE + 32'h10;
		bus_access(0, "write_read", 1'b1, adr, 32'hcafe_f00d, 4'hf);
		bus_access(0, "write_read", 1'b0, adr, '0, 4'hf);
		adr = `WB_MEM_BASE + 32'h40;
		bus_access(1, "byte_lanes", 1'b1, adr, 32'h0123_4567, 4'hf);
		for (int i = 0; i < N_BYTE_OPS; i++) begin
			dat = $random(seed);
			sel = wb_sel_t'($random(seed));
			bus_access(1, "byte_lanes", 1'b1, adr, dat, sel);
			bus_access(1, "byte_lanes", 1'b0, adr, '0, 4'hf);
		end
		// The write just above the window would land on this word if it reached the memory
		adr = `WB_MEM_BASE;
		bus_access(2, "decode_fail", 1'b1, adr, 32'h5a5a_a5a5, 4'hf);
		// Just below and just above the window
		bus_access(2, "decode_fail", 1'b0, `WB_MEM_BASE - 32'd4, '0, 4'hf);
		bus_access(2, "decode_fail", 1'b1, `WB_MEM_LIMIT + 32'd1, 32'hdead_beef, 4'hf);
		bus_access(2, "decode_fail", 1'b0, adr, '0, 4'hf);
		fork
			master_traffic(0);
			master_traffic(1);
			master_traffic(2);
			master_traffic(3);
		join
		// Master 3 takes the last grant so the next round starts at 0
		bus_access(3, "rr_order", 1'b0, `WB_MEM_BASE, '0, 4'hf);
		done_order.delete();
		fork
			bus_access(0, "rr_order", 1'b0, `WB_MEM_BASE, '0, 4'hf);
			bus_access(1, "rr_order", 1'b0, `WB_MEM_BASE + 32'h100, '0, 4'hf);
			bus_access(2, "rr_order", 1'b0, `WB_MEM_BASE + 32'h200, '0, 4'hf);
			bus_access(3, "rr_order", 1'b0, `WB_MEM_BASE + 32'h300, '0, 4'hf);
		join
		for (int i = 0; i < `WB_N_MASTERS; i++) begin
			assert (done_order[i] == i) else begin
				val_errs++;
				$display("error rr_order: completion %0d expected master %0d actual master %0d",
					i, i, done_order[i]);
			end
		end
		done_order.delete();
		fork
			bus_access(0, "rr_wrap", 1'b0, `WB_MEM_BASE, '0, 4'hf);
			bus_access(2, "rr_wrap", 1'b0, `WB_MEM_BASE + 32'h200, '0, 4'hf);
		join
		assert (done_order[0] == 0) else begin
			val_errs++;
			$display("error rr_wrap: first completion expected master 0 actual master %0d",
				done_order[0]);
		end
		while (txn_q.size() != 0) begin
			@(negedge clk);
		end
		$display("checks done: %0d value errors, %0d other errors", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: wb_mem_subsys.f
+incdir+include
rtl/wb_bus_pkg.sv
rtl/wb_ic_pkg.sv
rtl/wb_rr_arbiter.sv
rtl/wb_master_port.sv
rtl/wb_decode_err_slave.sv
rtl/wb_interconnect_4x1.sv
rtl/wb_sram_slave.sv
rtl/wb_mem_subsys.sv
bench/wb_clk_gen.sv
bench/wb_mem_subsys_tb.sv

// File: Bender.yml
package:
  name: wb_mem_subsys

sources:
  - include_dirs:
      - include
    files:
      - rtl/wb_bus_pkg.sv
      - rtl/wb_ic_pkg.sv
      - rtl/wb_rr_arbiter.sv
      - rtl/wb_master_port.sv
      - rtl/wb_decode_err_slave.sv
      - rtl/wb_interconnect_4x1.sv
      - rtl/wb_sram_slave.sv
      - rtl/wb_mem_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/wb_clk_gen.sv
      - bench/wb_mem_subsys_tb.sv
